//--- hdl/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// bytes per fetched bus line, two instructions
`define LINE_BYTES 8

`define REG_COUNT 16

// instruction queue entries
`define IQ_DEPTH 8

`define ALU_STAGES 2    // issue to writeback latency in cycles

// value every register holds after reset
`define REG_RESET_VAL 32'h0000_0000

`endif

//--- hdl/core_pkg.sv
package core_pkg;

	typedef logic [31:0] word_t;    // register value
	typedef logic [31:0] addr_t;    // byte address
	typedef logic [31:0] inst_t;
	typedef logic [63:0] line_t;    // lower address in the low half
	typedef logic [3:0]  reg_id_t;

	// opcode field, bits 31..28
	typedef enum logic [3:0] {
		NOP  = 4'd0,
		ADD,
		SUB,
		AND,
		XOR,
		ADDI,
		BNE
	} opcode_t;

	typedef enum logic [1:0] {
		IDLE,
		REQ,    // read open on the bus
		DRAIN   // read open but its line is stale
	} fetch_state_t;

endpackage

//--- hdl/core_if.sv
`timescale 1ns/100ps

// one ALU instruction per valid cycle, no back-pressure
interface issue_if;
	import core_pkg::*;

	logic    valid;
	opcode_t op;
	reg_id_t rd;
	word_t   a;
	word_t   b;     // already the immediate for ADDI

	modport src (output valid, op, rd, a, b);
	modport sink (input valid, op, rd, a, b);

endinterface

// combinational operand read
interface reg_read_if;
	import core_pkg::*;

	reg_id_t rs1;
	reg_id_t rs2;
	word_t   val1;
	word_t   val2;

	modport user (output rs1, rs2, input val1, val2);
	modport file (input rs1, rs2, output val1, val2);

endinterface

//--- hdl/fetch_ctrl.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module fetch_ctrl (
	input  logic            clk,
	input  logic            reset,
	output logic            bus_req,
	output core_pkg::addr_t bus_addr,
	input  logic            bus_resp,
	input  core_pkg::line_t bus_data,
	input  logic [3:0]      free_cnt,
	input  logic            redirect,
	input  core_pkg::addr_t redirect_addr,
	output logic            line_valid,
	output core_pkg::line_t line_data,
	output logic            skip_low
);
	import core_pkg::*;

	fetch_state_t state, state_nxt;
	addr_t fetch_addr;  // next instruction to fetch, may sit in the upper half
	addr_t req_addr;    // held on the bus while a read is open
	addr_t line_base;

	assign line_base = fetch_addr & ~addr_t'(`LINE_BYTES - 1);

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				// a line can bring two instructions
				if (!redirect && free_cnt >= 4'd2)
					state_nxt = REQ;
			end
			REQ: begin
				if (bus_resp)
					state_nxt = IDLE;
				else if (redirect)
					state_nxt = DRAIN;
			end
			DRAIN: begin
				if (bus_resp)
					state_nxt = IDLE;   // stale line dropped here
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			fetch_addr <= '0;
			req_addr <= '0;
		end else begin
			state <= state_nxt;
			if (redirect)
				fetch_addr <= redirect_addr;
			else if (state == REQ && bus_resp)
				fetch_addr <= line_base + addr_t'(`LINE_BYTES);
			if (state == IDLE && state_nxt == REQ)
				req_addr <= line_base;
		end
	end

	assign bus_req = (state != IDLE);   // drops the cycle after bus_resp
	assign bus_addr = req_addr;

	// a redirect in the response cycle also kills the line
	assign line_valid = (state == REQ) && bus_resp && !redirect;
	assign line_data = bus_data;
	assign skip_low = fetch_addr[$clog2(`LINE_BYTES) - 1];

endmodule

//--- hdl/inst_queue.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module inst_queue (
	input  logic            clk,
	input  logic            reset,
	input  logic            line_valid,
	input  core_pkg::line_t line_data,
	input  logic            skip_low,
	input  logic            pop,
	input  logic            flush,
	output core_pkg::inst_t head,
	output logic            empty,
	output logic [3:0]      free_cnt
);
	import core_pkg::*;

	inst_t mem [`IQ_DEPTH];
	logic [2:0] wr_ptr;     // wraps at the depth of 8
	logic [2:0] rd_ptr;
	logic [3:0] count;
	logic [1:0] n_wr;       // instructions written this cycle
	inst_t lo_inst;
	inst_t hi_inst;

	assign lo_inst = line_data[31:0];
	assign hi_inst = line_data[63:32];
	assign n_wr = !line_valid ? 2'd0 : (skip_low ? 2'd1 : 2'd2);

	always_ff @(posedge clk) begin
		if (line_valid) begin
			if (skip_low) begin
				mem[wr_ptr] <= hi_inst;     // branch target in the odd slot
			end else begin
				mem[wr_ptr] <= lo_inst;
				mem[wr_ptr + 3'd1] <= hi_inst;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			wr_ptr <= wr_ptr + {1'b0, n_wr};
			if (pop)
				rd_ptr <= rd_ptr + 3'd1;
			count <= count + {2'b00, n_wr} - {3'b000, pop};
		end
	end

	assign head = mem[rd_ptr];
	assign empty = (count == 4'd0);
	assign free_cnt = 4'(`IQ_DEPTH) - count;

endmodule

//--- hdl/dispatch.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module dispatch (
	input  logic              clk,
	input  logic              reset,
	input  core_pkg::inst_t   head,
	input  logic              empty,
	output logic              pop,
	output logic              flush,
	reg_read_if.user          rd,
	issue_if.src              iss,
	input  logic              wb_valid,
	input  core_pkg::reg_id_t wb_reg,
	output logic              redirect,
	output core_pkg::addr_t   redirect_addr
);
	import core_pkg::*;

	addr_t pc;                          // address of the queue head
	logic [`REG_COUNT-1:0] busy;        // scoreboard, set while a write is pending
	logic [`REG_COUNT-1:0] set_mask;
	logic [`REG_COUNT-1:0] clr_mask;

	opcode_t op;
	reg_id_t f_rd;
	reg_id_t f_rs1;
	reg_id_t f_rs2;
	word_t imm_ext;
	logic hazard;
	logic go;           // head leaves the queue this cycle
	logic is_alu;
	logic taken;

	// field decode
	assign op = opcode_t'(head[31:28]);
	assign f_rd = head[27:24];
	assign f_rs1 = head[23:20];
	assign f_rs2 = head[19:16];
	assign imm_ext = {{16{head[15]}}, head[15:0]};

	assign rd.rs1 = f_rs1;
	assign rd.rs2 = f_rs2;

	// all three fields are checked whatever the opcode uses
	assign hazard = busy[f_rd] | busy[f_rs1] | busy[f_rs2];
	assign go = !empty && !hazard;

	assign is_alu = (op == ADD) || (op == SUB) || (op == AND) ||
		(op == XOR) || (op == ADDI);
	assign taken = (op == BNE) && (rd.val1 != rd.val2);

	assign pop = go;                    // NOP and a not-taken BNE just retire
	assign redirect = go && taken;
	assign flush = go && taken;         // wrong-path entries are dropped
	assign redirect_addr = pc + {imm_ext[29:0], 2'b00};

	// ALU issue
	assign iss.valid = go && is_alu;
	assign iss.op = op;
	assign iss.rd = f_rd;
	assign iss.a = rd.val1;
	assign iss.b = (op == ADDI) ? imm_ext : rd.val2;

	always_comb begin
		set_mask = '0;
		clr_mask = '0;
		if (go && is_alu && f_rd != 4'd0)
			set_mask[f_rd] = 1'b1;      // r0 never waits on a write
		if (wb_valid)
			clr_mask[wb_reg] = 1'b1;
	end

	// a bit clears on the edge where the write lands in the register file
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			busy <= '0;
		end else begin
			busy <= (busy & ~clr_mask) | set_mask;
			if (redirect)
				pc <= redirect_addr;
			else if (pop)
				pc <= pc + 32'd4;
		end
	end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module reg_file (
	input  logic              clk,
	input  logic              reset,
	reg_read_if.file          rd,
	input  logic              wb_valid,
	input  core_pkg::reg_id_t wb_reg,
	input  core_pkg::word_t   wb_data
);
	import core_pkg::*;

	word_t regs [`REG_COUNT];

	// one write port, r0 is never written
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= `REG_RESET_VAL;
		end else if (wb_valid && wb_reg != 4'd0) begin
			regs[wb_reg] <= wb_data;
		end
	end

	// no bypass, a write shows up on the next cycle
	assign rd.val1 = (rd.rs1 == 4'd0) ? '0 : regs[rd.rs1];
	assign rd.val2 = (rd.rs2 == 4'd0) ? '0 : regs[rd.rs2];

endmodule

//--- hdl/alu_pipe.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module alu_pipe (
	input  logic              clk,
	input  logic              reset,
	issue_if.sink             iss,
	output logic              wb_valid,
	output core_pkg::reg_id_t wb_reg,
	output core_pkg::word_t   wb_data
);
	import core_pkg::*;

	logic [`ALU_STAGES-1:0] vld;    // one valid bit per stage
	opcode_t s1_op;
	reg_id_t s1_rd;
	word_t s1_a;
	word_t s1_b;
	word_t s1_res;

	always_ff @(posedge clk) begin
		if (reset)
			vld <= '0;
		else
			vld <= {vld[`ALU_STAGES-2:0], iss.valid};
	end

	// stage 1 operand registers
	always_ff @(posedge clk) begin
		s1_op <= iss.op;
		s1_rd <= iss.rd;
		s1_a <= iss.a;
		s1_b <= iss.b;
	end

	always_comb begin
		case (s1_op)
			ADD, ADDI: s1_res = s1_a + s1_b;    // b carries the immediate
			SUB:       s1_res = s1_a - s1_b;
			AND:       s1_res = s1_a & s1_b;
			XOR:       s1_res = s1_a ^ s1_b;
			default:   s1_res = '0;
		endcase
	end

	// stage 2 result registers
	always_ff @(posedge clk) begin
		wb_reg <= s1_rd;
		wb_data <= s1_res;
	end

	assign wb_valid = vld[`ALU_STAGES-1];

endmodule

//--- hdl/core_top.sv
`timescale 1ns/100ps

module core_top (
	input  logic              clk,
	input  logic              reset,
	output logic              bus_req,
	output core_pkg::addr_t   bus_addr,
	input  logic              bus_resp,
	input  core_pkg::line_t   bus_data,
	output logic              wb_valid,
	output core_pkg::reg_id_t wb_reg,
	output core_pkg::word_t   wb_data
);
	import core_pkg::*;

	logic line_valid;
	line_t line_data;
	logic skip_low;
	logic [3:0] free_cnt;
	logic pop;
	logic flush;
	inst_t head;
	logic empty;
	logic redirect;
	addr_t redirect_addr;

	issue_if iss_bus ();
	reg_read_if rr_bus ();

	fetch_ctrl fetch_i (
		.clk           (clk),
		.reset         (reset),
		.bus_req       (bus_req),
		.bus_addr      (bus_addr),
		.bus_resp      (bus_resp),
		.bus_data      (bus_data),
		.free_cnt      (free_cnt),
		.redirect      (redirect),
		.redirect_addr (redirect_addr),
		.line_valid    (line_valid),
		.line_data     (line_data),
		.skip_low      (skip_low)
	);

	inst_queue iq_i (
		.clk        (clk),
		.reset      (reset),
		.line_valid (line_valid),
		.line_data  (line_data),
		.skip_low   (skip_low),
		.pop        (pop),
		.flush      (flush),
		.head       (head),
		.empty      (empty),
		.free_cnt   (free_cnt)
	);

	dispatch disp_i (
		.clk           (clk),
		.reset         (reset),
		.head          (head),
		.empty         (empty),
		.pop           (pop),
		.flush         (flush),
		.rd            (rr_bus.user),
		.iss           (iss_bus.src),
		.wb_valid      (wb_valid),
		.wb_reg        (wb_reg),
		.redirect      (redirect),
		.redirect_addr (redirect_addr)
	);

	reg_file rf_i (
		.clk      (clk),
		.reset    (reset),
		.rd       (rr_bus.file),
		.wb_valid (wb_valid),
		.wb_reg   (wb_reg),
		.wb_data  (wb_data)
	);

	alu_pipe alu_i (
		.clk      (clk),
		.reset    (reset),
		.iss      (iss_bus.sink),
		.wb_valid (wb_valid),
		.wb_reg   (wb_reg),
		.wb_data  (wb_data)
	);

endmodule

//--- sim/core_properties.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module core_properties (
	input logic            clk,
	input logic            reset,
	input logic            bus_req,
	input core_pkg::addr_t bus_addr,
	input logic            bus_resp,
	input logic            wb_valid,
	input logic            redirect,
	input core_pkg::addr_t redirect_addr
);
	import core_pkg::*;

	int fail_cnt = 0;
	logic req_q;
	logic redir_pend;   // redirect seen, new request not issued yet
	addr_t redir_line;

	always_ff @(posedge clk) begin
		if (reset) begin
			req_q <= 1'b0;
			redir_pend <= 1'b0;
			redir_line <= '0;
		end else begin
			req_q <= bus_req;
			if (redirect) begin
				redir_pend <= 1'b1;
				redir_line <= redirect_addr & ~addr_t'(`LINE_BYTES - 1);
			end else if (bus_req && !req_q) begin
				redir_pend <= 1'b0;
			end
		end
	end

	reset_quiet: assert property (@(posedge clk) reset |=> !bus_req && !wb_valid)
		else begin
			$error("bus_req or wb_valid high after reset");
			fail_cnt++;
		end

	addr_aligned: assert property (@(posedge clk) disable iff (reset)
		bus_req |-> (bus_addr & addr_t'(`LINE_BYTES - 1)) == '0)
		else begin
			$error("bus_addr %h is not line aligned", bus_addr);
			fail_cnt++;
		end

	// request held until the response
	req_stable: assert property (@(posedge clk) disable iff (reset)
		bus_req && !bus_resp |=> bus_req && $stable(bus_addr))
		else begin
			$error("bus_req or bus_addr changed before bus_resp");
			fail_cnt++;
		end

	req_drop: assert property (@(posedge clk) disable iff (reset) bus_resp |=> !bus_req)
		else begin
			$error("bus_req still high the cycle after bus_resp");
			fail_cnt++;
		end

	redirect_line: assert property (@(posedge clk) disable iff (reset)
		redir_pend && bus_req && !req_q |-> bus_addr == redir_line)
		else begin
			$error("request after a redirect went to %h, not %h", bus_addr, redir_line);
			fail_cnt++;
		end

endmodule

bind core_top core_properties props_i (
	.clk           (clk),
	.reset         (reset),
	.bus_req       (bus_req),
	.bus_addr      (bus_addr),
	.bus_resp      (bus_resp),
	.wb_valid      (wb_valid),
	.redirect      (redirect),
	.redirect_addr (redirect_addr)
);

//--- sim/core_tb.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module core_tb;
	import core_pkg::*;

	logic clk;
	logic reset = 1'b1;
	logic bus_req;
	addr_t bus_addr;
	logic bus_resp = 1'b0;
	line_t bus_data = '0;
	logic wb_valid;
	reg_id_t wb_reg;
	word_t wb_data;

	inst_t prog [16];
	reg_id_t exp_reg [$];     // golden writeback sequence
	word_t exp_data [$];
	int target_wb = -1;       // index of the first writeback after the taken branch
	addr_t target_line = '0;

	int rst_cnt = 0;
	logic [31:0] lfsr = 32'h08f6f850;
	logic pending = 1'b0;
	logic [1:0] delay = '0;
	logic req_q = 1'b0;

	int wb_cnt = 0;
	int cmp_err = 0;
	int main_err = 0;
	int n_pass = 0;
	int n_fail = 0;
	bit timed_out = 1'b0;
	bit r0_seen = 1'b0;
	bit target_ok = 1'b0;
	bit target_req_seen = 1'b0;

	core_top dut_i (
		.clk      (clk),
		.reset    (reset),
		.bus_req  (bus_req),
		.bus_addr (bus_addr),
		.bus_resp (bus_resp),
		.bus_data (bus_data),
		.wb_valid (wb_valid),
		.wb_reg   (wb_reg),
		.wb_data  (wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		rst_cnt <= rst_cnt + 1;
		if (rst_cnt == 3)
			reset <= 1'b0;    // four edges in reset
	end

	function automatic inst_t enc(opcode_t op, reg_id_t rd, reg_id_t rs1, reg_id_t rs2,
			logic [15:0] imm);
		return {op, rd, rs1, rs2, imm};
	endfunction

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
	endfunction

	// outside the program the memory holds NOPs carrying the address
	function automatic inst_t mem_word(addr_t a);
		if (a < 32'd64)
			return prog[a[5:2]];
		return {4'h0, a[31:4] ^ {24'd0, a[3:0]}};
	endfunction

	task automatic load_program();
		prog[0] = enc(ADDI, 4'd1, 4'd0, 4'd0, 16'd5);
		prog[1] = enc(ADDI, 4'd2, 4'd1, 4'd0, 16'd3);       // needs r1
		prog[2] = enc(SUB, 4'd3, 4'd2, 4'd1, 16'd0);
		prog[3] = enc(XOR, 4'd4, 4'd3, 4'd2, 16'd0);
		prog[4] = enc(AND, 4'd5, 4'd4, 4'd2, 16'd0);
		prog[5] = enc(ADDI, 4'd0, 4'd5, 4'd0, 16'd7);       // discarded write to r0
		prog[6] = enc(ADD, 4'd6, 4'd0, 4'd5, 16'd0);
		prog[7] = enc(BNE, 4'd0, 4'd1, 4'd6, 16'd4);        // taken, to word 11
		prog[8] = enc(ADDI, 4'd7, 4'd0, 4'd0, 16'h0111);
		prog[9] = enc(ADDI, 4'd8, 4'd0, 4'd0, 16'h0222);
		prog[10] = enc(ADD, 4'd9, 4'd1, 4'd1, 16'd0);
		prog[11] = enc(ADDI, 4'd7, 4'd1, 4'd0, 16'hFFFE);   // odd slot target
		prog[12] = enc(BNE, 4'd0, 4'd5, 4'd6, 16'hFFF4);    // equal, falls through
		prog[13] = enc(ADD, 4'd8, 4'd7, 4'd5, 16'd0);
		prog[14] = enc(SUB, 4'd9, 4'd0, 4'd8, 16'd0);
		prog[15] = enc(BNE, 4'd0, 4'd1, 4'd0, 16'd0);       // spins on itself
	endtask

	// in-order interpreter of the instruction set
	task automatic run_golden();
		word_t g [16];
		addr_t pc;
		inst_t w;
		opcode_t op;
		word_t a;
		word_t b;
		word_t imm;
		bit done;
		done = 1'b0;
		pc = '0;
		foreach (g[i])
			g[i] = '0;
		for (int step = 0; step < 64 && !done; step++) begin
			w = prog[pc[5:2]];
			op = opcode_t'(w[31:28]);
			a = g[w[23:20]];
			b = g[w[19:16]];
			imm = {{16{w[15]}}, w[15:0]};
			pc = pc + 32'd4;
			case (op)
				ADD:  exp_data.push_back(a + b);
				SUB:  exp_data.push_back(a - b);
				AND:  exp_data.push_back(a & b);
				XOR:  exp_data.push_back(a ^ b);
				ADDI: exp_data.push_back(a + imm);
				BNE: begin
					if (a != b && imm == 0) begin
						done = 1'b1;
					end else if (a != b) begin
						pc = pc - 32'd4 + (imm << 2);
						if (target_wb < 0) begin
							target_wb = exp_data.size();
							target_line = pc & ~addr_t'(`LINE_BYTES - 1);
						end
					end
				end
				default: ;
			endcase
			if (op inside {ADD, SUB, AND, XOR, ADDI}) begin
				exp_reg.push_back(w[27:24]);
				if (w[27:24] != 4'd0)
					g[w[27:24]] = exp_data[$];   // r0 is never written
			end
		end
	endtask

	// bus memory, answers after 1 to 4 cycles
	always @(posedge clk) begin
		logic [31:0] s1;
		logic [31:0] s2;
		s1 = lfsr_next(lfsr);
		s2 = lfsr_next(s1);
		if (reset) begin
			bus_resp <= 1'b0;
			pending <= 1'b0;
		end else begin
			bus_resp <= 1'b0;
			if (pending) begin
				if (delay == 2'd0) begin
					bus_resp <= 1'b1;
					bus_data <= {mem_word(bus_addr + 32'd4), mem_word(bus_addr)};
					pending <= 1'b0;
				end else begin
					delay <= delay - 2'd1;
				end
			end else if (bus_req && !bus_resp) begin
				pending <= 1'b1;
				delay <= {s1[0], s2[0]};
				lfsr <= s2;
			end
		end
	end

	// writeback monitor against the golden sequence
	always @(negedge clk) begin
		if (reset) begin
			req_q = 1'b0;
		end else begin
			if (bus_req && !req_q && bus_addr == target_line && wb_cnt == target_wb)
				target_req_seen = 1'b1;
			if (wb_valid) begin
				if (wb_cnt < exp_reg.size()) begin
					assert (wb_reg == exp_reg[wb_cnt] && wb_data == exp_data[wb_cnt]) else begin
						$display("Fail writeback_order: expected r%0d = %h, actual r%0d = %h",
							exp_reg[wb_cnt], exp_data[wb_cnt], wb_reg, wb_data);
						cmp_err++;
					end
					if (wb_cnt == target_wb)
						target_ok = (wb_reg == exp_reg[wb_cnt] && wb_data == exp_data[wb_cnt]);
				end else begin
					$display("extra writeback r%0d = %h after the program ended", wb_reg, wb_data);
					cmp_err++;
				end
				if (wb_reg == 4'd0)
					r0_seen = 1'b1;
				wb_cnt++;
			end
			req_q = bus_req;
		end
	end

	task automatic report_test(input string name, input bit ok);
		if (ok) begin
			$display("test %s: ok", name);
			n_pass++;
		end else begin
			$display("test %s: failed", name);
			n_fail++;
		end
	endtask

	initial begin
		int n;
		int e0;
		load_program();
		run_golden();

		e0 = main_err;
		n = 0;
		@(negedge clk);
		while (!bus_req && n < 50) begin
			assert (!wb_valid) else begin
				$display("writeback seen before the first bus request");
				main_err++;
			end
			@(negedge clk);
			n++;
		end
		if (!bus_req) begin
			$display("timeout waiting for the first bus request");
			timed_out = 1'b1;
		end else begin
			assert (bus_addr == 32'h0) else begin
				$display("Fail reset_state: expected bus_addr %h, actual %h", 32'h0, bus_addr);
				main_err++;
			end
		end
		report_test("reset_state", !timed_out && main_err == e0);

		n = 0;
		@(posedge clk);
		while (!timed_out && wb_cnt < exp_reg.size() && n < 3000) begin
			@(posedge clk);
			n++;
		end
		if (!timed_out && wb_cnt < exp_reg.size()) begin
			$display("timeout with %0d of %0d writebacks seen", wb_cnt, exp_reg.size());
			timed_out = 1'b1;
		end
		report_test("writeback_order", !timed_out && cmp_err == 0);

		e0 = main_err;
		assert (r0_seen) else begin
			$display("no writeback to r0 was seen");
			main_err++;
		end
		report_test("r0_write", main_err == e0);

		e0 = main_err;
		assert (target_req_seen) else begin
			$display("the branch target line was not requested after the branch");
			main_err++;
		end
		assert (target_ok) else begin
			$display("the first writeback after the taken branch is not the target's");
			main_err++;
		end
		report_test("taken_branch", main_err == e0);

		// the closing loop writes nothing
		repeat (40) @(posedge clk);
		e0 = main_err;
		assert (wb_cnt == exp_reg.size()) else begin
			$display("Fail wb_count: expected %0d, actual %0d", exp_reg.size(), wb_cnt);
			main_err++;
		end
		report_test("wb_count", !timed_out && main_err == e0);

		@(negedge clk);
		e0 = main_err;
		assert (dut_i.props_i.fail_cnt == 0) else begin
			$display("%0d bus or redirect assertions failed", dut_i.props_i.fail_cnt);
			main_err++;
		end
		report_test("properties", main_err == e0);

		$display("%0d tests: %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
		if (n_fail == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+hdl
hdl/core_pkg.sv
hdl/core_if.sv
hdl/fetch_ctrl.sv
hdl/inst_queue.sv
hdl/dispatch.sv
hdl/reg_file.sv
hdl/alu_pipe.sv
hdl/core_top.sv
sim/core_properties.sv
sim/core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= core_tb
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --assert -j 0
SIM_ARGS ?= +verilator+error+limit+100
PASS_MSG ?= TEST RESULT: PASS

SOURCES := $(shell grep -v '^+' filelist.f)
HEADERS := $(wildcard hdl/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): filelist.f $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f filelist.f

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
